/* Makefile */
# Verilator build and run of the UART testbench
VERILATOR ?= verilator
TOP       ?= tb_uart
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
+incdir+.
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_top.sv
tb_uart.sv

/* tb_uart.sv */
/*
 * Self-checking testbench for uart_top with inputs driven on the falling edge
 * Serial loopback ties i_rxd to o_txd while the loopback bit is set
 */
`default_nettype none

`include "uart_defs.svh"

module tb_uart;

    // Wait limits in clock cycles and in register polls
    localparam int EDGE_LIMIT = 40 * `UART_CLKS_PER_BIT;
    localparam int POLL_LIMIT = 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 bus_stb;
    logic                 bus_we;
    uart_pkg::reg_addr_t  bus_addr;
    uart_pkg::bus_data_t  bus_wdata;
    logic                 rxd;
    logic                 rxd_drv;
    logic                 cts_n;
    uart_pkg::bus_data_t  bus_rdata;
    logic                 bus_rvalid;
    logic                 irq;
    logic                 txd;
    logic                 rts_n;
    logic                 loopback;
    logic                 read_pending;
    logic [31:0]          rng_state;
    uart_pkg::byte_t      expect_q[$];

    // Serial line back into the receiver
    assign rxd = loopback ? txd : rxd_drv;

    uart_top uart_top_inst
    (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_bus_stb    (bus_stb),
        .i_bus_we     (bus_we),
        .i_bus_addr   (bus_addr),
        .i_bus_wdata  (bus_wdata),
        .i_rxd        (rxd),
        .i_cts_n      (cts_n),
        .o_bus_rdata  (bus_rdata),
        .o_bus_rvalid (bus_rvalid),
        .o_int        (irq),
        .o_txd        (txd),
        .o_rts_n      (rts_n)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ========================================================================
    // Checking helpers
    // ========================================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        assert (actual === expected)
        else
            abort_run($sformatf("Mismatch at time %0t: %s, got 0x%08h, expected 0x%08h",
                                $time, what, actual, expected));
    endtask

    // Read answer expected exactly one cycle after a read strobe
    always @(posedge clk)
        read_pending <= rst_n && bus_stb && !bus_we;

    always @(negedge clk)
        check_value(bus_rvalid, read_pending, "read valid timing");

    // 32-bit xorshift
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_byte(output uart_pkg::byte_t b);
        rng_state = xorshift32(rng_state);
        b = rng_state[7:0];
    endtask

    // ========================================================================
    // Register port
    // ========================================================================
    task automatic write_reg(input uart_pkg::reg_addr_t addr, input uart_pkg::bus_data_t data);
        @(negedge clk);
        bus_stb   = 1'b1;
        bus_we    = 1'b1;
        bus_addr  = addr;
        bus_wdata = data;
        @(negedge clk);
        bus_stb   = 1'b0;
        bus_we    = 1'b0;
    endtask

    task automatic read_reg(input uart_pkg::reg_addr_t addr, output uart_pkg::bus_data_t data);
        @(negedge clk);
        bus_stb  = 1'b1;
        bus_we   = 1'b0;
        bus_addr = addr;
        @(negedge clk);
        bus_stb  = 1'b0;
        // Answer registered on the edge after the strobe
        check_value(bus_rvalid, 1'b1, "read valid");
        data = bus_rdata;
    endtask

    // Poll FR until one bit reaches a level
    task automatic wait_flag(input int pos, input logic value, input string what);
        uart_pkg::bus_data_t fr;
        int polls;
        polls = 0;
        read_reg(`UART_REG_FR, fr);
        while (fr[pos] !== value)
        begin
            polls++;
            if (polls > POLL_LIMIT)
                abort_run($sformatf("Timeout at time %0t waiting for %s", $time, what));
            read_reg(`UART_REG_FR, fr);
        end
    endtask

    task automatic wait_int_level(input logic value);
        int waited;
        waited = 0;
        while (irq !== value)
        begin
            @(negedge clk);
            waited++;
            if (waited > EDGE_LIMIT)
                abort_run($sformatf("Timeout at time %0t waiting for interrupt %0b",
                                    $time, value));
        end
    endtask

    task automatic wait_rts_level(input logic value);
        int waited;
        waited = 0;
        while (rts_n !== value)
        begin
            @(negedge clk);
            waited++;
            if (waited > EDGE_LIMIT)
                abort_run($sformatf("Timeout at time %0t waiting for RTS level %0b",
                                    $time, value));
        end
    endtask

    // ========================================================================
    // Serial checks
    // ========================================================================
    // Start edge followed by mid-bit samples one bit time apart
    task automatic check_frame(input uart_pkg::byte_t expected);
        int waited;
        int i;
        waited = 0;
        while (txd === 1'b1)
        begin
            @(negedge clk);
            waited++;
            if (waited > EDGE_LIMIT)
                abort_run($sformatf("Timeout at time %0t waiting for a start bit", $time));
        end
        repeat (`UART_HALF_BIT) @(negedge clk);
        check_value(txd, 1'b0, "start bit");
        for (i = 0; i < 8; i++)
        begin
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            check_value(txd, expected[i], $sformatf("data bit %0d", i));
        end
        repeat (`UART_CLKS_PER_BIT) @(negedge clk);
        check_value(txd, 1'b1, "stop bit");
        // Rest of the stop bit
        repeat (`UART_HALF_BIT - 1)
        begin
            @(negedge clk);
            check_value(txd, 1'b1, "stop bit hold");
        end
    endtask

    // Read back every expected byte in order
    task automatic drain_rx();
        uart_pkg::bus_data_t rd;
        uart_pkg::byte_t exp_byte;
        while (expect_q.size() > 0)
        begin
            wait_flag(`UART_FR_RXFE, 1'b0, "receive data");
            read_reg(`UART_REG_DR, rd);
            exp_byte = expect_q.pop_front();
            check_value(rd[7:0], exp_byte, "received byte");
        end
    endtask

    task automatic send_random(input int count);
        uart_pkg::byte_t b;
        repeat (count)
        begin
            next_byte(b);
            expect_q.push_back(b);
            write_reg(`UART_REG_DR, {24'd0, b});
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial
    begin
        uart_pkg::bus_data_t rd;
        uart_pkg::byte_t b;
        int i;

        rst_n     = 1'b0;
        bus_stb   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        rxd_drv   = 1'b1;
        cts_n     = 1'b0;
        loopback  = 1'b0;
        rng_state = 32'd7;

        repeat (8) @(negedge clk);
        check_value(txd, 1'b1, "idle line in reset");
        check_value(rts_n, 1'b1, "RTS in reset");
        check_value(irq, 1'b0, "interrupt in reset");
        rst_n = 1'b1;

        // Transmit framing with CTS low
        next_byte(b);
        write_reg(`UART_REG_DR, {24'd0, b});
        check_frame(b);
        wait_flag(`UART_FR_TXFE, 1'b1, "transmit FIFO empty");
        read_reg(`UART_REG_FR, rd);
        check_value(rd[`UART_FR_BUSY], 1'b0, "FR busy after frame");
        check_value(rd[`UART_FR_CTS], 1'b1, "FR CTS asserted");
        check_value(rd[`UART_FR_TXFF], 1'b0, "FR transmit not full");

        // CTS holds the frame back
        cts_n = 1'b1;
        repeat (4) @(negedge clk);
        next_byte(b);
        write_reg(`UART_REG_DR, {24'd0, b});
        repeat (30 * `UART_CLKS_PER_BIT)
        begin
            @(negedge clk);
            check_value(txd, 1'b1, "line idle while CTS high");
        end
        read_reg(`UART_REG_FR, rd);
        check_value(rd[`UART_FR_BUSY], 1'b1, "FR busy with CTS high");
        check_value(rd[`UART_FR_CTS], 1'b0, "FR CTS clear");
        cts_n = 1'b0;
        check_frame(b);
        wait_flag(`UART_FR_TXFE, 1'b1, "transmit FIFO empty after CTS");

        // Loopback order
        loopback = 1'b1;
        send_random(5);
        drain_rx();
        read_reg(`UART_REG_FR, rd);
        check_value(rd[`UART_FR_RXFE], 1'b1, "FR receive empty");
        wait_flag(`UART_FR_TXFE, 1'b1, "transmit FIFO empty after loopback");

        // Receive FIFO full and RTS
        send_random(`UART_FIFO_DEPTH);
        read_reg(`UART_REG_FR, rd);
        check_value(rd[`UART_FR_TXFF], 1'b1, "FR transmit full");
        wait_flag(`UART_FR_RXFF, 1'b1, "receive FIFO full");
        wait_rts_level(1'b1);
        read_reg(`UART_REG_DR, rd);
        b = expect_q.pop_front();
        check_value(rd[7:0], b, "first byte of full FIFO");
        wait_rts_level(1'b0);
        send_random(1);
        drain_rx();
        wait_flag(`UART_FR_TXFE, 1'b1, "transmit FIFO empty after full test");

        // Transmit interrupt with the FIFO empty
        write_reg(`UART_REG_CR, 32'd1 << `UART_CR_TXIE);
        read_reg(`UART_REG_IIR, rd);
        check_value(rd[`UART_IIR_TX], 1'b1, "IIR transmit bit");
        check_value(irq, 1'b1, "transmit interrupt");
        write_reg(`UART_REG_CR, 32'd0);
        read_reg(`UART_REG_IIR, rd);
        check_value(rd, 32'd0, "IIR with interrupts disabled");
        check_value(irq, 1'b0, "interrupt disabled");

        // Receive interrupt at the half mark
        write_reg(`UART_REG_CR, 32'd1 << `UART_CR_RXIE);
        send_random(`UART_FIFO_HALF - 1);
        wait_flag(`UART_FR_TXFE, 1'b1, "seven bytes sent");
        check_value(irq, 1'b0, "interrupt below threshold");
        send_random(1);
        wait_int_level(1'b1);
        read_reg(`UART_REG_IIR, rd);
        check_value(rd[`UART_IIR_RX], 1'b1, "IIR receive bit");
        read_reg(`UART_REG_DR, rd);
        b = expect_q.pop_front();
        check_value(rd[7:0], b, "byte read at threshold");
        wait_int_level(1'b0);
        drain_rx();
        write_reg(`UART_REG_CR, 32'd0);

        // Register access
        write_reg(`UART_REG_CR, 32'h0000_005A);
        read_reg(`UART_REG_CR, rd);
        check_value(rd, 32'h0000_005A, "CR readback");
        write_reg(`UART_REG_CR, 32'd0);
        read_reg(`UART_REG_CR, rd);
        check_value(rd, 32'd0, "CR cleared");
        write_reg(12'h040, 32'hFFFF_FFFF);
        for (i = 0; i < 3; i++)
        begin
            read_reg(12'h040 + 12'(i * 4), rd);
            check_value(rd, `UART_UNMAPPED_DATA, "unmapped offset");
        end
        repeat (4) @(negedge clk);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* uart_defs.svh */
/*
 * Bit timing and FIFO depth are fixed at build time
 * FIFO depth stays at 16 to match the 5-bit pointer and count types
 */
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// System clocks per serial bit
`define UART_CLKS_PER_BIT   16
// Confirmed start edge to middle of start bit
`define UART_HALF_BIT       (`UART_CLKS_PER_BIT / 2)

// FIFO size and interrupt threshold
`define UART_FIFO_DEPTH     16
`define UART_FIFO_HALF      8

// Register byte offsets
`define UART_REG_DR         12'h000
`define UART_REG_CR         12'h014
`define UART_REG_FR         12'h018
`define UART_REG_IIR        12'h01C

// CR interrupt enables
`define UART_CR_TXIE        5
`define UART_CR_RXIE        4

// FR bit positions, DCD and DSR read as 0
`define UART_FR_TXFE        7
`define UART_FR_RXFF        6
`define UART_FR_TXFF        5
`define UART_FR_RXFE        4
`define UART_FR_BUSY        3
`define UART_FR_CTS         0

// IIR bit positions
`define UART_IIR_TX         2
`define UART_IIR_RX         1

`define UART_UNMAPPED_DATA  32'h00C0FFEE

`endif

/* uart_fifo.sv */
/*
 * Byte FIFO in flip-flops with wrap-bit pointers
 * Push while full and pop while empty are ignored
 */
`default_nettype none

`include "uart_defs.svh"

module uart_fifo
(
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire                   i_push,
    input  wire uart_pkg::byte_t  i_data,
    input  wire                   i_pop,
    output uart_pkg::byte_t       o_data,
    output uart_pkg::fifo_cnt_t   o_count,
    output logic                  o_full,
    output logic                  o_empty
);

    uart_pkg::byte_t      mem [`UART_FIFO_DEPTH];
    uart_pkg::fifo_ptr_t  wr_ptr;
    uart_pkg::fifo_ptr_t  rd_ptr;
    logic                 do_push;
    logic                 do_pop;

    // Occupancy from pointer distance, wrap bit covers the full case
    assign o_count = wr_ptr - rd_ptr;
    assign o_full  = (o_count == uart_pkg::fifo_cnt_t'(`UART_FIFO_DEPTH));
    assign o_empty = (wr_ptr == rd_ptr);

    // Head entry always visible
    assign o_data  = mem[rd_ptr[3:0]];

    // Qualified strobes
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            // Same-cycle push and pop leaves the count unchanged
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge i_clk)
    begin
        if (do_push)
            mem[wr_ptr[3:0]] <= i_data;
    end

endmodule

`default_nettype wire

/* uart_pkg.sv */
/*
 * Shared types of the UART
 */
`default_nettype none

package uart_pkg;

    // One serial data byte
    typedef logic [7:0]  byte_t;

    // FIFO occupancy 0..16 and pointer with wrap bit
    typedef logic [4:0]  fifo_cnt_t;
    typedef logic [4:0]  fifo_ptr_t;

    // Register port
    typedef logic [11:0] reg_addr_t;
    typedef logic [31:0] bus_data_t;

    // Clock count within one serial bit
    typedef logic [9:0]  bit_cnt_t;

    // Transmit frame sequencer
    typedef enum logic [1:0]
    {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // Receive frame sequencer
    typedef enum logic [2:0]
    {
        RX_IDLE,
        RX_START,
        RX_START_MID,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire

/* uart_regs.sv */
/*
 * Register block on a single-cycle strobe port, read data one cycle later
 * Interrupts are levels recomputed every cycle, no clear register
 */
`default_nettype none

`include "uart_defs.svh"

module uart_regs
(
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_bus_stb,
    input  wire                       i_bus_we,
    input  wire uart_pkg::reg_addr_t  i_bus_addr,
    input  wire uart_pkg::bus_data_t  i_bus_wdata,
    output uart_pkg::bus_data_t       o_bus_rdata,
    output logic                      o_bus_rvalid,
    output logic                      o_tx_push,
    output uart_pkg::byte_t           o_tx_data,
    input  wire uart_pkg::fifo_cnt_t  i_tx_count,
    input  wire                       i_tx_full,
    input  wire                       i_tx_empty,
    output logic                      o_rx_pop,
    input  wire uart_pkg::byte_t      i_rx_data,
    input  wire uart_pkg::fifo_cnt_t  i_rx_count,
    input  wire                       i_rx_full,
    input  wire                       i_rx_empty,
    input  wire                       i_cts,
    output logic                      o_int
);

    logic                 wr_stb;
    logic                 rd_stb;
    logic [7:0]           cr;
    logic                 tx_irq;
    logic                 rx_irq;
    uart_pkg::bus_data_t  fr_word;
    uart_pkg::bus_data_t  iir_word;

    // ========================================================================
    // Access decode
    // ========================================================================
    assign wr_stb = i_bus_stb && i_bus_we;
    assign rd_stb = i_bus_stb && !i_bus_we;

    // DR write pushes, DR read pops
    assign o_tx_push = wr_stb && (i_bus_addr == `UART_REG_DR);
    assign o_tx_data = i_bus_wdata[7:0];
    assign o_rx_pop  = rd_stb && (i_bus_addr == `UART_REG_DR);

    // Enabled interrupt status
    assign tx_irq = cr[`UART_CR_TXIE]
                    && (i_tx_count <= uart_pkg::fifo_cnt_t'(`UART_FIFO_HALF));
    assign rx_irq = cr[`UART_CR_RXIE]
                    && (i_rx_count >= uart_pkg::fifo_cnt_t'(`UART_FIFO_HALF));

    // Status words
    always_comb
    begin
        fr_word                = '0;
        fr_word[`UART_FR_TXFE] = i_tx_empty;
        fr_word[`UART_FR_RXFF] = i_rx_full;
        fr_word[`UART_FR_TXFF] = i_tx_full;
        fr_word[`UART_FR_RXFE] = i_rx_empty;
        // Busy while any byte waits or shifts
        fr_word[`UART_FR_BUSY] = !i_tx_empty;
        fr_word[`UART_FR_CTS]  = i_cts;

        iir_word               = '0;
        iir_word[`UART_IIR_TX] = tx_irq;
        iir_word[`UART_IIR_RX] = rx_irq;
    end

    // ========================================================================
    // Control state
    // ========================================================================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            cr           <= '0;
            o_bus_rvalid <= 1'b0;
            o_int        <= 1'b0;
        end
        else
        begin
            if (wr_stb && (i_bus_addr == `UART_REG_CR))
                cr <= i_bus_wdata[7:0];
            // Read answer one cycle after strobe
            o_bus_rvalid <= rd_stb;
            o_int        <= tx_irq || rx_irq;
        end
    end

    // Read mux, sampled on the strobe
    always_ff @(posedge i_clk)
    begin
        if (rd_stb)
        begin
            case (i_bus_addr)
                `UART_REG_DR:  o_bus_rdata <= {24'd0, i_rx_data};
                `UART_REG_CR:  o_bus_rdata <= {24'd0, cr};
                `UART_REG_FR:  o_bus_rdata <= fr_word;
                `UART_REG_IIR: o_bus_rdata <= iir_word;
                default:       o_bus_rdata <= `UART_UNMAPPED_DATA;
            endcase
        end
    end

endmodule

`default_nettype wire

/* uart_rx.sv */
/*
 * 8N1 receiver with a 5-sample start filter and mid-bit sampling
 * No framing check on the stop bit, a new frame waits while the FIFO is full
 */
`default_nettype none

`include "uart_defs.svh"

module uart_rx
(
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire                   i_rxd,
    input  wire                   i_full,
    output logic                  o_push,
    output uart_pkg::byte_t       o_data,
    output logic                  o_rts_n
);

    logic [4:0]           rxd_d;
    logic                 start_seen;
    uart_pkg::rx_state_t  state;
    uart_pkg::bit_cnt_t   bit_cnt;
    logic [2:0]           bit_idx;
    logic                 half_done;
    logic                 bit_done;

    // ========================================================================
    // Line filter
    // ========================================================================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            rxd_d <= 5'h1f;
        else
            rxd_d <= {rxd_d[3:0], i_rxd};
    end

    // Clean high to low edge, middle sample ignored
    assign start_seen = (rxd_d[4:3] == 2'b11) && (rxd_d[1:0] == 2'b00);

    // Counter checkpoints
    assign half_done = (bit_cnt == uart_pkg::bit_cnt_t'(`UART_HALF_BIT - 1));
    assign bit_done  = (bit_cnt == uart_pkg::bit_cnt_t'(`UART_CLKS_PER_BIT - 1));

    // Frame done at mid stop bit
    assign o_push = (state == uart_pkg::RX_STOP) && bit_done;

    // ========================================================================
    // Frame sequencer
    // ========================================================================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state   <= uart_pkg::RX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            o_rts_n <= 1'b1;
        end
        else
        begin
            // Counter runs unless restarted below
            bit_cnt <= bit_cnt + 1'b1;
            case (state)
                uart_pkg::RX_IDLE:
                    if (i_full)
                        o_rts_n <= 1'b1;
                    else
                    begin
                        state   <= uart_pkg::RX_START;
                        o_rts_n <= 1'b0;
                    end
                uart_pkg::RX_START:
                begin
                    // Held at zero until the edge is confirmed
                    bit_cnt <= '0;
                    if (start_seen)
                        state <= uart_pkg::RX_START_MID;
                end
                uart_pkg::RX_START_MID:
                    if (half_done)
                    begin
                        state   <= uart_pkg::RX_DATA;
                        bit_cnt <= '0;
                        bit_idx <= '0;
                    end
                uart_pkg::RX_DATA:
                    if (bit_done)
                    begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= uart_pkg::RX_STOP;
                    end
                uart_pkg::RX_STOP:
                    if (bit_done)
                        state <= uart_pkg::RX_IDLE;
                default:
                    state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge i_clk)
    begin
        if ((state == uart_pkg::RX_DATA) && bit_done)
            o_data <= {rxd_d[0], o_data[7:1]};
    end

endmodule

`default_nettype wire

/* uart_top.sv */
/*
 * UART top with 16-byte transmit and receive FIFOs, 8N1 frames only
 */
`default_nettype none

module uart_top
(
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_bus_stb,
    input  wire                       i_bus_we,
    input  wire uart_pkg::reg_addr_t  i_bus_addr,
    input  wire uart_pkg::bus_data_t  i_bus_wdata,
    input  wire                       i_rxd,
    input  wire                       i_cts_n,
    output uart_pkg::bus_data_t       o_bus_rdata,
    output logic                      o_bus_rvalid,
    output logic                      o_int,
    output logic                      o_txd,
    output logic                      o_rts_n
);

    // Transmit path
    logic                 tx_push;
    uart_pkg::byte_t      tx_wdata;
    uart_pkg::byte_t      tx_head;
    uart_pkg::fifo_cnt_t  tx_count;
    logic                 tx_full;
    logic                 tx_empty;
    logic                 tx_pop;
    logic                 cts;

    // Receive path
    logic                 rx_push;
    uart_pkg::byte_t      rx_byte;
    uart_pkg::byte_t      rx_head;
    uart_pkg::fifo_cnt_t  rx_count;
    logic                 rx_full;
    logic                 rx_empty;
    logic                 rx_pop;

    uart_regs regs_inst
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_bus_stb    (i_bus_stb),
        .i_bus_we     (i_bus_we),
        .i_bus_addr   (i_bus_addr),
        .i_bus_wdata  (i_bus_wdata),
        .o_bus_rdata  (o_bus_rdata),
        .o_bus_rvalid (o_bus_rvalid),
        .o_tx_push    (tx_push),
        .o_tx_data    (tx_wdata),
        .i_tx_count   (tx_count),
        .i_tx_full    (tx_full),
        .i_tx_empty   (tx_empty),
        .o_rx_pop     (rx_pop),
        .i_rx_data    (rx_head),
        .i_rx_count   (rx_count),
        .i_rx_full    (rx_full),
        .i_rx_empty   (rx_empty),
        .i_cts        (cts),
        .o_int        (o_int)
    );

    // Bus writes in, transmitter pops out
    uart_fifo tx_fifo_inst
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (tx_push),
        .i_data  (tx_wdata),
        .i_pop   (tx_pop),
        .o_data  (tx_head),
        .o_count (tx_count),
        .o_full  (tx_full),
        .o_empty (tx_empty)
    );

    // Receiver pushes in, bus reads pop out
    uart_fifo rx_fifo_inst
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (rx_push),
        .i_data  (rx_byte),
        .i_pop   (rx_pop),
        .o_data  (rx_head),
        .o_count (rx_count),
        .o_full  (rx_full),
        .o_empty (rx_empty)
    );

    uart_tx tx_inst
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (tx_head),
        .i_empty (tx_empty),
        .i_cts_n (i_cts_n),
        .o_pop   (tx_pop),
        .o_cts   (cts),
        .o_txd   (o_txd)
    );

    uart_rx rx_inst
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_rxd   (i_rxd),
        .i_full  (rx_full),
        .o_push  (rx_push),
        .o_data  (rx_byte),
        .o_rts_n (o_rts_n)
    );

endmodule

`default_nettype wire

/* uart_tx.sv */
/*
 * 8N1 transmitter paced by a free-running bit counter
 * A frame starts only after three consecutive low CTS samples
 */
`default_nettype none

`include "uart_defs.svh"

module uart_tx
(
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire uart_pkg::byte_t  i_data,
    input  wire                   i_empty,
    input  wire                   i_cts_n,
    output logic                  o_pop,
    output logic                  o_cts,
    output logic                  o_txd
);

    logic [2:0]           cts_sync;
    logic                 cts_ok;
    uart_pkg::bit_cnt_t   bit_cnt;
    logic                 bit_tick;
    uart_pkg::tx_state_t  state;
    logic [2:0]           bit_idx;

    // ========================================================================
    // CTS synchronizer
    // ========================================================================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            cts_sync <= 3'b111;
        else
            cts_sync <= {cts_sync[1:0], i_cts_n};
    end

    // Oldest sample reported as active-high CTS
    assign o_cts  = !cts_sync[2];
    assign cts_ok = (cts_sync == 3'b000);

    // ========================================================================
    // Bit timing
    // ========================================================================
    assign bit_tick = (bit_cnt == uart_pkg::bit_cnt_t'(`UART_CLKS_PER_BIT - 1));

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || bit_tick)
            bit_cnt <= '0;
        else
            bit_cnt <= bit_cnt + 1'b1;
    end

    // Head byte retired at the end of the stop bit
    assign o_pop = (state == uart_pkg::TX_STOP) && bit_tick;

    // ========================================================================
    // Frame sequencer
    // ========================================================================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state   <= uart_pkg::TX_IDLE;
            bit_idx <= '0;
            o_txd   <= 1'b1;
        end
        else if (bit_tick)
        begin
            case (state)
                uart_pkg::TX_IDLE:
                    if (!i_empty && cts_ok)
                    begin
                        // Start bit
                        state <= uart_pkg::TX_START;
                        o_txd <= 1'b0;
                    end
                uart_pkg::TX_START:
                begin
                    state   <= uart_pkg::TX_DATA;
                    bit_idx <= '0;
                    o_txd   <= i_data[0];
                end
                uart_pkg::TX_DATA:
                    if (bit_idx == 3'd7)
                    begin
                        // Stop bit
                        state <= uart_pkg::TX_STOP;
                        o_txd <= 1'b1;
                    end
                    else
                    begin
                        bit_idx <= bit_idx + 3'd1;
                        o_txd   <= i_data[bit_idx + 3'd1];
                    end
                default:
                begin
                    state <= uart_pkg::TX_IDLE;
                    o_txd <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
